/* source/eth_fd_pkg.sv */
/*
 * Shared types of the rule store. Widths are fixed at 2048 words of 30 bits.
 */

package eth_fd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Rule geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// 2048 rule words.
	localparam int RULE_ADDR_W = 11;
	localparam int RULE_DATA_W = 30;
	localparam int RULE_WORDS  = 1 << RULE_ADDR_W;

	typedef logic [RULE_ADDR_W-1:0] rule_addr_t;

	// Also serves as the write mask, a set bit takes the new data bit.
	typedef logic [RULE_DATA_W-1:0] rule_word_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Client write command
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		rule_addr_t addr;
		rule_word_t mask;
		rule_word_t data;
	} rule_wr_cmd_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Driven by the access port.
	// Held stable from req rising until the acknowledge.
	typedef struct packed {
		logic       req;
		logic       we;
		rule_addr_t addr;
		rule_word_t wdata;
	} mem_cmd_t;

endpackage

/* source/eth_fd_dram_port.sv */
/*
 * Strobes are sampled only in idle and are otherwise ignored. A write wins over a read
 * in the same cycle. A partial-mask write costs two memory transactions.
 */

`timescale 1ns/1ps

module eth_fd_dram_port
	import eth_fd_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	// Client side.
	input  logic         read_req,
	input  rule_addr_t   read_addr,
	input  logic         write_req,
	input  rule_wr_cmd_t write_cmd,
	output logic         done,
	output rule_word_t   read_data,

	// Memory bus.
	output mem_cmd_t     mem_cmd,
	input  logic         mem_ack,
	input  rule_word_t   mem_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ_MEM,
		ST_WRITE_MEM
	} state_t;

	state_t     state;

	// Acknowledge of the previous cycle.
	logic       mem_ack_prev;
	logic       xact_end;

	// Masked write waiting for its read half.
	logic       write_pending;

	rule_word_t mask_q;
	rule_word_t merged;

	// New data where the mask is set, old data elsewhere.
	function automatic rule_word_t merge_word(
		rule_word_t new_data,
		rule_word_t old_data,
		rule_word_t mask
	);
		merge_word = (new_data & mask) | (old_data & ~mask);
	endfunction

	// Transaction ends the cycle after the acknowledge pulse.
	assign xact_end = mem_ack_prev && !mem_ack;

	assign merged = merge_word(mem_cmd.wdata, mem_rdata, mask_q);

	// The word of the last operation sits in wdata until the next one starts.
	assign read_data = mem_cmd.wdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Held write mask
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A plain read clears it, so the merge passes the read word through.
	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			if (write_req) begin
				mask_q <= write_cmd.mask;
			end else if (read_req) begin
				mask_q <= '0;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Access FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= ST_IDLE;
			mem_cmd       <= '0;
			done          <= 1'b0;
			write_pending <= 1'b0;
			mem_ack_prev  <= 1'b0;
		end else begin
			done         <= 1'b0;
			mem_ack_prev <= mem_ack;

			case (state)
				ST_IDLE: begin
					if (write_req) begin
						mem_cmd.req   <= 1'b1;
						mem_cmd.addr  <= write_cmd.addr;
						mem_cmd.wdata <= write_cmd.data;

						if (&write_cmd.mask) begin
							// Full mask, no need to read first.
							state      <= ST_WRITE_MEM;
							mem_cmd.we <= 1'b1;
						end else begin
							state         <= ST_READ_MEM;
							mem_cmd.we    <= 1'b0;
							write_pending <= 1'b1;
						end
					end else if (read_req) begin
						state        <= ST_READ_MEM;
						mem_cmd.req  <= 1'b1;
						mem_cmd.we   <= 1'b0;
						mem_cmd.addr <= read_addr;
					end
				end

				ST_READ_MEM: begin
					if (mem_ack) begin
						mem_cmd.req <= 1'b0;
					end else if (xact_end) begin
						mem_cmd.wdata <= merged;

						if (write_pending) begin
							// Second half of a masked write, same address.
							state         <= ST_WRITE_MEM;
							mem_cmd.req   <= 1'b1;
							mem_cmd.we    <= 1'b1;
							write_pending <= 1'b0;
						end else begin
							state <= ST_IDLE;
							done  <= 1'b1;
						end
					end
				end

				ST_WRITE_MEM: begin
					if (mem_ack) begin
						mem_cmd.req <= 1'b0;
					end else if (xact_end) begin
						state      <= ST_IDLE;
						mem_cmd.we <= 1'b0;
						done       <= 1'b1;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

/* source/eth_fd_ack_timer.sv */
/*
 * ACK_LATENCY must be at least 1. One acknowledge per request, and req must
 * drop before the next request is counted.
 */

`timescale 1ns/1ps

module eth_fd_ack_timer
	import eth_fd_pkg::*;
#(
	parameter int ACK_LATENCY = 3
) (
	input  logic     clk,
	input  logic     rst_n,

	input  mem_cmd_t mem_cmd,
	output logic     mem_ack
);

	localparam int CNT_W = $clog2(ACK_LATENCY + 1);

	// Nonzero while a request is being timed.
	logic [CNT_W-1:0] count;

	// Ready to time the next request.
	logic             armed;

	logic             start;

	assign start = armed && mem_cmd.req;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Latency counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
			armed <= 1'b1;
		end else begin
			if (start) begin
				count <= CNT_W'(ACK_LATENCY);
				armed <= 1'b0;
			end else begin
				if (count != '0) begin
					count <= count - 1'b1;
				end

				// Port drops req on the edge after the acknowledge.
				if (!mem_cmd.req) begin
					armed <= 1'b1;
				end
			end
		end
	end

	// Last counted cycle, ACK_LATENCY cycles after the first cycle of req.
	assign mem_ack = (count == CNT_W'(1));

endmodule

/* source/eth_fd_rule_ram.sv */
/*
 * No reset on the array, contents are undefined until written. Accesses take effect
 * only on the acknowledge cycle.
 */

`timescale 1ns/1ps

module eth_fd_rule_ram
	import eth_fd_pkg::*;
(
	input  logic       clk,

	input  mem_cmd_t   mem_cmd,
	input  logic       mem_ack,
	output rule_word_t mem_rdata
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	rule_word_t mem [RULE_WORDS];

	// Write half.
	always_ff @(posedge clk) begin
		if (mem_ack && mem_cmd.we) begin
			mem[mem_cmd.addr] <= mem_cmd.wdata;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Holds until the next read acknowledge, writes leave it alone.
	always_ff @(posedge clk) begin
		if (mem_ack && !mem_cmd.we) begin
			mem_rdata <= mem[mem_cmd.addr];
		end
	end

endmodule

/* source/eth_fd_rule_store.sv */
/*
 * One operation at a time, the client waits for done. Read and full-write latency is
 * ACK_LATENCY + 2 cycles, a masked write takes twice that.
 */

`timescale 1ns/1ps

module eth_fd_rule_store
	import eth_fd_pkg::*;
#(
	// Cycles from memory request to acknowledge, at least 1.
	parameter int ACK_LATENCY = 3
) (
	input  logic         clk,
	input  logic         rst_n,

	input  logic         read_req,
	input  rule_addr_t   read_addr,

	input  logic         write_req,
	input  rule_wr_cmd_t write_cmd,

	output logic         done,
	output rule_word_t   read_data
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal memory bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	mem_cmd_t   mem_cmd;
	logic       mem_ack;
	rule_word_t mem_rdata;

	// Access port.
	eth_fd_dram_port u_port (
		.clk       (clk),
		.rst_n     (rst_n),
		.read_req  (read_req),
		.read_addr (read_addr),
		.write_req (write_req),
		.write_cmd (write_cmd),
		.done      (done),
		.read_data (read_data),
		.mem_cmd   (mem_cmd),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	// Models the memory response time.
	eth_fd_ack_timer #(
		.ACK_LATENCY (ACK_LATENCY)
	) u_timer (
		.clk     (clk),
		.rst_n   (rst_n),
		.mem_cmd (mem_cmd),
		.mem_ack (mem_ack)
	);

	// Rule words.
	eth_fd_rule_ram u_ram (
		.clk       (clk),
		.mem_cmd   (mem_cmd),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

endmodule

/* test/eth_fd_rule_store_chk.sv */
/*
 * Protocol checks on the access port, active only outside reset.
 */

`timescale 1ns/1ps

module eth_fd_rule_store_chk
	import eth_fd_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     done,
	input logic     mem_ack,
	input mem_cmd_t mem_cmd
);

	// Done is a single-cycle pulse.
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Command held until the acknowledge.
	a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_cmd.req && !mem_ack) |=> (mem_cmd.req && $stable(mem_cmd.we)
			&& $stable(mem_cmd.addr) && $stable(mem_cmd.wdata)))
		else $error("memory command changed before its acknowledge");

	a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack |=> !mem_cmd.req)
		else $error("req still high in the cycle after mem_ack");

	// No acknowledge without a request.
	a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack |-> mem_cmd.req)
		else $error("mem_ack raised while req was low");

endmodule

bind eth_fd_dram_port eth_fd_rule_store_chk u_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.done    (done),
	.mem_ack (mem_ack),
	.mem_cmd (mem_cmd)
);

/* test/eth_fd_rule_store_tb.sv */
/*
 * The RAM has no reset. Every address is written with a full mask before it is read.
 * Checks wait on done only, so any ACK_LATENCY of 1 or more runs unchanged.
 */

`timescale 1ns/1ps

module eth_fd_rule_store_tb
	import eth_fd_pkg::*;
#(
	parameter int ACK_LATENCY = 3
);

	localparam int N_BASIC  = 16;
	localparam int N_ADDR   = 64;
	localparam int N_RANDOM = 300;
	// Basic pairs, masked-write case, dual strobe case, random preload and sequence.
	localparam int N_OPS = 2 * N_BASIC + 5 + 2 + N_ADDR + N_RANDOM;
	localparam int TIMEOUT_CYCLES = N_OPS * (2 * ACK_LATENCY + 6) + 100;

	logic         clk;
	logic         rst_n;
	logic         read_req;
	rule_addr_t   read_addr;
	logic         write_req;
	rule_wr_cmd_t write_cmd;
	logic         done;
	rule_word_t   read_data;

	// Reference copy of the rule words.
	rule_word_t   model_mem [RULE_WORDS];
	rule_word_t   expect_q [$];
	int           errors = 0;
	int           checks = 0;
	int           cycles = 0;

	eth_fd_rule_store #(
		.ACK_LATENCY (ACK_LATENCY)
	) DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.read_req  (read_req),
		.read_addr (read_addr),
		.write_req (write_req),
		.write_cmd (write_cmd),
		.done      (done),
		.read_data (read_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and compares
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The mask picks the new data bit by bit.
	function automatic rule_word_t ref_merge(
		rule_word_t new_data,
		rule_word_t old_data,
		rule_word_t mask
	);
		rule_word_t result;
		for (int i = 0; i < RULE_DATA_W; i++) begin
			result[i] = mask[i] ? new_data[i] : old_data[i];
		end
		return result;
	endfunction

	// Spread the random addresses over the whole range.
	function automatic rule_addr_t addr_of(int k);
		return rule_addr_t'(k * 31 + 5);
	endfunction

	task automatic check_word(input string name, input rule_word_t exp, input rule_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// One expected word per operation, taken at each done pulse.
	always @(negedge clk) begin : compare_done
		rule_word_t exp_word;
		if (rst_n && done) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("Done pulse at %0t with no operation outstanding", $time);
			end else begin
				exp_word = expect_q.pop_front();
				check_word("read_data", exp_word, read_data);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Client operations
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Called on a falling edge. Returns on the falling edge that shows done.
	task automatic wait_done();
		while (!done) begin
			@(negedge clk);
		end
	endtask

	task automatic write_word(input rule_addr_t addr, input rule_word_t mask,
		input rule_word_t data);
		model_mem[addr] = ref_merge(data, model_mem[addr], mask);
		expect_q.push_back(model_mem[addr]);
		write_cmd = '{addr: addr, mask: mask, data: data};
		write_req = 1'b1;
		@(negedge clk);
		write_req = 1'b0;
		wait_done();
	endtask

	task automatic read_word(input rule_addr_t addr);
		expect_q.push_back(model_mem[addr]);
		read_addr = addr;
		read_req  = 1'b1;
		@(negedge clk);
		read_req  = 1'b0;
		wait_done();
	endtask

	// The write wins and the read is dropped.
	// The quiet window outlasts one more read, so a late second done shows up.
	task automatic write_with_read(input rule_addr_t waddr, input rule_word_t data,
		input rule_addr_t raddr);
		model_mem[waddr] = ref_merge(data, model_mem[waddr], '1);
		expect_q.push_back(model_mem[waddr]);
		write_cmd = '{addr: waddr, mask: '1, data: data};
		read_addr = raddr;
		write_req = 1'b1;
		read_req  = 1'b1;
		@(negedge clk);
		write_req = 1'b0;
		read_req  = 1'b0;
		wait_done();
		repeat (ACK_LATENCY + 4) begin
			@(negedge clk);
			check_bit("done", 1'b0, done);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		rule_word_t mask;
		int         kind;
		int         idx;

		void'($urandom(15));
		rst_n     = 1'b0;
		read_req  = 1'b0;
		read_addr = '0;
		write_req = 1'b0;
		write_cmd = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// Quiet after reset.
		repeat (10) begin
			@(negedge clk);
			check_bit("done", 1'b0, done);
			check_bit("mem_cmd.req", 1'b0, DUT.u_port.mem_cmd.req);
		end

		for (int k = 0; k < N_BASIC; k++) begin
			write_word(rule_addr_t'(2047 - k * 97), '1, rule_word_t'($urandom));
		end
		for (int k = 0; k < N_BASIC; k++) begin
			read_word(rule_addr_t'(2047 - k * 97));
		end

		// Masked merge over a known word and then a mask of zero.
		write_word(rule_addr_t'(100), '1, 30'h2AAA_AAAA);
		write_word(rule_addr_t'(100), 30'h0F0F_0F0F, 30'h1555_5555);
		read_word(rule_addr_t'(100));
		write_word(rule_addr_t'(100), '0, 30'h3FFF_FFFF);
		read_word(rule_addr_t'(100));

		write_with_read(rule_addr_t'(200), 30'h0ABC_DEF1, rule_addr_t'(100));
		read_word(rule_addr_t'(200));

		for (int k = 0; k < N_ADDR; k++) begin
			write_word(addr_of(k), '1, rule_word_t'($urandom));
		end
		for (int n = 0; n < N_RANDOM; n++) begin
			kind = int'($urandom % 3);
			idx  = int'($urandom % N_ADDR);
			mask = rule_word_t'($urandom);
			case (kind)
				0: read_word(addr_of(idx));
				1: write_word(addr_of(idx), '1, rule_word_t'($urandom));
				default: write_word(addr_of(idx), mask, rule_word_t'($urandom));
			endcase
		end

		repeat (3) @(negedge clk);
		if (expect_q.size() != 0) begin
			errors++;
			$display("%0d operations ended without a done pulse", expect_q.size());
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Run limit.
	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* compile.f */
source/eth_fd_pkg.sv
source/eth_fd_dram_port.sv
source/eth_fd_ack_timer.sv
source/eth_fd_rule_ram.sv
source/eth_fd_rule_store.sv
test/eth_fd_rule_store_chk.sv
test/eth_fd_rule_store_tb.sv

/* Makefile */
# Verilator build and run of the rule store testbench.
# Example: make check ACK_LATENCY=7

VERILATOR   ?= verilator
TOP         ?= eth_fd_rule_store_tb
ACK_LATENCY ?= 3
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir_lat$(ACK_LATENCY)
VFLAGS      ?= --binary --timing --assert -j 0
LOG         ?= $(BUILD_DIR)/sim.log

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check latencies clean

all: check

build: $(SIM_BIN)

# One build directory per latency, rebuilt only when a source changes.
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GACK_LATENCY=$(ACK_LATENCY) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed with ACK_LATENCY=$(ACK_LATENCY)"

latencies:
	$(MAKE) check ACK_LATENCY=1
	$(MAKE) check ACK_LATENCY=3
	$(MAKE) check ACK_LATENCY=7

clean:
	rm -rf $(BUILD_DIR) obj_dir_lat*
